/* include/vcmp_consts.svh */
`ifndef VCMP_CONSTS_SVH
`define VCMP_CONSTS_SVH

// operand slice width and the byte lanes it holds
`define VCMP_DATA_WIDTH 64
`define VCMP_BE_WIDTH (`VCMP_DATA_WIDTH / 8)

// element width code, 0 is 8 bits up to 3 for 64 bits
`define VCMP_SEW_WIDTH 2

// each byte slot is carry inject, eight difference bits and an extension bit
`define VCMP_LANE_BITS 10
`define VCMP_SUB_WIDTH (`VCMP_DATA_WIDTH + 17)

`define VCMP_ENABLE_64 1

`endif

/* rtl/vcmp_types_pkg.sv */
`include "vcmp_consts.svh"

package vcmp_types_pkg;

  // one 64-bit slice of a vector register
  typedef logic [`VCMP_DATA_WIDTH-1:0] vdata_t;

  // one bit per byte lane, used for flags and packed masks
  typedef logic [`VCMP_BE_WIDTH-1:0] vbe_t;

  // element width code
  typedef logic [`VCMP_SEW_WIDTH-1:0] vsew_t;

  // difference in byte-slot lane format, the top bit catches the last carry
  typedef logic [`VCMP_SUB_WIDTH-1:0] vsub_t;

endpackage

/* rtl/vcmp_op_pkg.sv */
package vcmp_op_pkg;

  typedef enum logic [3:0] {
    VMINU  = 4'd0,
    VMIN   = 4'd1,
    VMAXU  = 4'd2,
    VMAX   = 4'd3,
    VMSEQ  = 4'd4,
    VMSNE  = 4'd5,
    VMSLTU = 4'd6,
    VMSLT  = 4'd7,
    VMSLEU = 4'd8,
    VMSLE  = 4'd9
  } vcmp_op_e;

  // elements are two's complement for these opcodes
  function automatic logic vcmp_op_is_signed(vcmp_op_e op);
    case (op)
      VMIN, VMAX, VMSLT, VMSLE: return 1'b1;
      default:                  return 1'b0;
    endcase
  endfunction

  function automatic logic vcmp_op_is_max(vcmp_op_e op);
    case (op)
      VMAXU, VMAX: return 1'b1;
      default:     return 1'b0;
    endcase
  endfunction

  // compares write one mask bit per element instead of data
  function automatic logic vcmp_op_is_mask(vcmp_op_e op);
    case (op)
      VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE: return 1'b1;
      default:                                    return 1'b0;
    endcase
  endfunction

endpackage

/* rtl/vsub_lanes.sv */
`timescale 1ns/1ps
`include "vcmp_consts.svh"

module vsub_lanes
  import vcmp_types_pkg::*;
  import vcmp_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  vcmp_op_e op,
  input  vsew_t    sew,
  input  vdata_t   vec0,
  input  vdata_t   vec1,
  output vsub_t    sub_result,
  output vdata_t   s1_vec0,
  output vdata_t   s1_vec1,
  output vsew_t    s1_sew,
  output vcmp_op_e s1_op,
  output logic     max_sel,
  output logic     s1_valid
);

  localparam int NB = `VCMP_BE_WIDTH;
  localparam int LB = `VCMP_LANE_BITS;

  vsub_t      lane_a;
  vsub_t      lane_b;
  vsub_t      diff;
  logic       is_signed;
  logic [3:0] elem_bytes;
  logic       first_b;
  logic       last_b;
  logic       ext_a;
  logic       ext_b;

  // vec0 and the inverted vec1 are spread into 10-bit slots so that one
  // wide adder produces every element difference at once
  always_comb begin
    is_signed  = vcmp_op_is_signed(op);
    elem_bytes = 4'd1 << sew;
    lane_a     = '0;
    lane_b     = '0;
    first_b    = 1'b0;
    last_b     = 1'b0;
    ext_a      = 1'b0;
    ext_b      = 1'b0;
    for (int i = 0; i < NB; i++) begin
      first_b = (4'(i) & (elem_bytes - 4'd1)) == 4'd0;
      last_b  = ((4'(i) + 4'd1) & (elem_bytes - 4'd1)) == 4'd0;

      // top byte of an element gets its sign or zero extension, an inner
      // byte gets 1 + 0 so the carry passes through the extension bit
      if (last_b) begin
        ext_a = is_signed & vec0[i*8+7];
        ext_b = ~(is_signed & vec1[i*8+7]);
      end else begin
        ext_a = 1'b1;
        ext_b = 1'b0;
      end

      // slot bit 0 is 1 + 1 at an element boundary which cuts the chain
      // and injects the +1 of the two's complement, 1 + 0 passes it on
      lane_a[i*LB +: LB] = {ext_a, vec0[i*8 +: 8], 1'b1};
      lane_b[i*LB +: LB] = {ext_b, ~vec1[i*8 +: 8], first_b};
    end
    diff = lane_a + lane_b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    sub_result <= diff;
    s1_vec0    <= vec0;
    s1_vec1    <= vec1;
    s1_sew     <= sew;
    s1_op      <= op;
    max_sel    <= vcmp_op_is_max(op);
  end

endmodule

/* rtl/vminmax_select.sv */
`timescale 1ns/1ps
`include "vcmp_consts.svh"

module vminmax_select
  import vcmp_types_pkg::*;
#(
  parameter bit ENABLE_64_BIT = `VCMP_ENABLE_64
) (
  input  logic   max_sel,
  input  vsew_t  sew,
  input  vdata_t vec0,
  input  vdata_t vec1,
  input  vsub_t  sub_result,
  output vdata_t minmax_result,
  output vbe_t   equal,
  output vbe_t   lt
);

  localparam int NB       = `VCMP_BE_WIDTH;
  localparam int LB       = `VCMP_LANE_BITS;
  localparam int NUM_SEWS = 1 << `VCMP_SEW_WIDTH;

  vbe_t  sgns   [NUM_SEWS];
  vbe_t  lts    [NUM_SEWS];
  vbe_t  equals [NUM_SEWS];
  vbe_t  sgn_bits;
  vsew_t sew_eff;

  // flags for every element width, selected afterwards by sew
  always_comb begin
    int msb;

    msb = 0;
    for (int j = 0; j < NUM_SEWS; j++) begin
      sgns[j]   = '0;
      lts[j]    = '0;
      equals[j] = '0;
      if (j < NUM_SEWS - 1 || ENABLE_64_BIT) begin
        for (int k = 0; k < (NB >> j); k++) begin
          equals[j][k] = 1'b1;
        end
        for (int i = 0; i < NB; i++) begin
          // extension bit of the element's top byte is the sign of vec0 - vec1
          msb = i | ((1 << j) - 1);
          sgns[j][i]     = sub_result[msb*LB + LB - 1];
          lts[j][i >> j] = sub_result[msb*LB + LB - 1];

          // any nonzero difference or extension bit breaks equality
          if (sub_result[i*LB + 1 +: LB - 1] != '0) begin
            equals[j][i >> j] = 1'b0;
          end
        end
      end
    end
  end

  always_comb begin
    // without 64-bit support the widest code falls back to 32-bit elements
    sew_eff  = (!ENABLE_64_BIT && sew == 2'd3) ? 2'd2 : sew;
    equal    = equals[sew_eff];
    lt       = lts[sew_eff];
    sgn_bits = sgns[sew_eff];

    // a sign that disagrees with max_sel keeps vec0, so max_sel low gives the min
    for (int i = 0; i < NB; i++) begin
      minmax_result[i*8 +: 8] = (sgn_bits[i] != max_sel) ? vec0[i*8 +: 8] : vec1[i*8 +: 8];
    end
  end

  // 32-bit elements take their signs from the top byte of each half
  always_comb begin
    if (!ENABLE_64_BIT && sew == 2'd3) begin
      assert (lt == vbe_t'({sub_result[8*LB-1], sub_result[4*LB-1]}))
        else $error("sew 3 not remapped to 32-bit elements");
    end
  end

endmodule

/* rtl/vcmp_mask_gen.sv */
`timescale 1ns/1ps
`include "vcmp_consts.svh"

module vcmp_mask_gen
  import vcmp_types_pkg::*;
  import vcmp_op_pkg::*;
(
  input  vcmp_op_e op,
  input  vsew_t    sew,
  input  vbe_t     equal,
  input  vbe_t     lt,
  output vbe_t     mask
);

  localparam int NB = `VCMP_BE_WIDTH;

  vbe_t valid_elems;
  vbe_t outcome;

  always_comb begin
    // only the low NB >> sew flags belong to real elements
    valid_elems = '0;
    for (int k = 0; k < NB; k++) begin
      if (k < (NB >> sew)) begin
        valid_elems[k] = 1'b1;
      end
    end

    case (op)
      VMSEQ:         outcome = equal;
      VMSNE:         outcome = ~equal;
      VMSLTU, VMSLT: outcome = lt;
      VMSLEU, VMSLE: outcome = lt | equal;
      default:       outcome = '0;
    endcase

    mask = outcome & valid_elems;
  end

  // a zero difference has a clear sign bit, so no element is both equal and below
  always_comb begin
    if (!$isunknown({equal, lt})) begin
      assert ((equal & lt) == '0)
        else $error("element flagged both equal and less-than, sew %0d", sew);
    end
  end

endmodule

/* rtl/vcmp_result_stage.sv */
`timescale 1ns/1ps

module vcmp_result_stage
  import vcmp_types_pkg::*;
  import vcmp_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     s1_valid,
  input  vcmp_op_e s1_op,
  input  vdata_t   minmax_result,
  input  vbe_t     mask,
  output logic     out_valid,
  output vdata_t   out_data,
  output logic     out_is_mask
);

  logic is_mask;

  assign is_mask = vcmp_op_is_mask(s1_op);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  // the mask lands in the low bits with zeros above
  always_ff @(posedge clk) begin
    out_is_mask <= is_mask;
    out_data    <= is_mask ? vdata_t'(mask) : minmax_result;
  end

  data_known: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !$isunknown(out_data))
    else $error("out_data unknown while out_valid");

endmodule

/* rtl/vcmp_unit.sv */
`timescale 1ns/1ps

module vcmp_unit
  import vcmp_types_pkg::*;
  import vcmp_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  vcmp_op_e op,
  input  vsew_t    sew,
  input  vdata_t   vec0,
  input  vdata_t   vec1,
  output logic     out_valid,
  output vdata_t   out_data,
  output logic     out_is_mask
);

  vsub_t    sub_result;
  vdata_t   s1_vec0;
  vdata_t   s1_vec1;
  vsew_t    s1_sew;
  vcmp_op_e s1_op;
  logic     max_sel;
  logic     s1_valid;
  vdata_t   minmax_result;
  vbe_t     equal;
  vbe_t     lt;
  vbe_t     mask;

  vsub_lanes u_sub (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .op         (op),
    .sew        (sew),
    .vec0       (vec0),
    .vec1       (vec1),
    .sub_result (sub_result),
    .s1_vec0    (s1_vec0),
    .s1_vec1    (s1_vec1),
    .s1_sew     (s1_sew),
    .s1_op      (s1_op),
    .max_sel    (max_sel),
    .s1_valid   (s1_valid)
  );

  vminmax_select u_sel (
    .max_sel       (max_sel),
    .sew           (s1_sew),
    .vec0          (s1_vec0),
    .vec1          (s1_vec1),
    .sub_result    (sub_result),
    .minmax_result (minmax_result),
    .equal         (equal),
    .lt            (lt)
  );

  vcmp_mask_gen u_mask (
    .op    (s1_op),
    .sew   (s1_sew),
    .equal (equal),
    .lt    (lt),
    .mask  (mask)
  );

  vcmp_result_stage u_out (
    .clk           (clk),
    .rst           (rst),
    .s1_valid      (s1_valid),
    .s1_op         (s1_op),
    .minmax_result (minmax_result),
    .mask          (mask),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_is_mask   (out_is_mask)
  );

endmodule

/* dv/vcmp_unit_tb.sv */
`timescale 1ns/1ps
`include "vcmp_consts.svh"

module vcmp_unit_tb
  import vcmp_types_pkg::*;
  import vcmp_op_pkg::*;
();

  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic     clk;
  logic     rst;
  logic     in_valid;
  vcmp_op_e op;
  vsew_t    sew;
  vdata_t   vec0;
  vdata_t   vec1;
  logic     out_valid;
  vdata_t   out_data;
  logic     out_is_mask;

  logic [31:0] lfsr;
  int          errors = 0;
  int          timeouts = 0;
  int          items_sent = 0;
  int          items_seen = 0;

  // expected results, two stages deep to line up with the DUT latency
  logic     exp0_valid;
  logic     exp1_valid;
  vdata_t   exp0_data;
  vdata_t   exp1_data;
  logic     exp0_is_mask;
  logic     exp1_is_mask;
  vcmp_op_e exp0_op;
  vcmp_op_e exp1_op;

  vcmp_unit dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .op          (op),
    .sew         (sew),
    .vec0        (vec0),
    .vec1        (vec1),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_is_mask (out_is_mask)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, one step for every bit that is taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return r;
  endfunction

  // top byte of each element gets one pattern, the lower bytes the other
  function automatic vdata_t fill_elems(vsew_t s, logic [7:0] top, logic [7:0] rest);
    vdata_t v;
    int     eb;
    eb = 1 << s;
    for (int i = 0; i < 8; i++) begin
      v[i*8 +: 8] = ((i % eb) == eb - 1) ? top : rest;
    end
    return v;
  endfunction

  // per-element reference built from the instruction definitions
  function automatic vdata_t expected_data(vcmp_op_e o, vsew_t s, vdata_t a, vdata_t b);
    int     width;
    vdata_t m;
    vdata_t flip;
    vdata_t x;
    vdata_t y;
    logic   less;
    logic   eq;
    vdata_t res;
    width = 8 << s;
    m     = (width == 64) ? '1 : ((64'd1 << width) - 64'd1);
    // flipping the sign bit maps two's complement order onto unsigned order
    flip  = (o inside {VMIN, VMAX, VMSLT, VMSLE}) ? (64'd1 << (width - 1)) : '0;
    res   = '0;
    for (int e = 0; e < 64 / width; e++) begin
      x    = ((a >> (e * width)) & m) ^ flip;
      y    = ((b >> (e * width)) & m) ^ flip;
      less = x < y;
      eq   = x == y;
      x    = x ^ flip;
      y    = y ^ flip;
      case (o)
        VMINU, VMIN:   res = res | ((less ? x : y) << (e * width));
        VMAXU, VMAX:   res = res | ((less ? y : x) << (e * width));
        VMSEQ:         res[e] = eq;
        VMSNE:         res[e] = !eq;
        VMSLTU, VMSLT: res[e] = less;
        default:       res[e] = less | eq;
      endcase
    end
    return res;
  endfunction

  task automatic send(vcmp_op_e o, vsew_t s, vdata_t a, vdata_t b);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    op       = o;
    sew      = s;
    vec0     = a;
    vec1     = b;
    items_sent++;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp0_valid <= 1'b0;
      exp1_valid <= 1'b0;
    end else begin
      exp0_valid <= in_valid;
      exp1_valid <= exp0_valid;
      if (out_valid) begin
        items_seen++;
      end
    end
    exp0_data    <= expected_data(op, sew, vec0, vec1);
    exp0_is_mask <= op inside {VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE};
    exp0_op      <= op;
    exp1_data    <= exp0_data;
    exp1_is_mask <= exp0_is_mask;
    exp1_op      <= exp0_op;
  end

  valid_check: assert property (@(posedge clk) disable iff (rst) out_valid == exp1_valid)
    else begin
      errors++;
      $display("FAIL valid_check expected %0b actual %0b", $sampled(exp1_valid),
               $sampled(out_valid));
    end

  data_check: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_data == exp1_data)
    else begin
      errors++;
      $display("FAIL data_check op %0d expected %h actual %h", $sampled(exp1_op),
               $sampled(exp1_data), $sampled(out_data));
    end

  mask_flag_check: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_is_mask == exp1_is_mask)
    else begin
      errors++;
      $display("FAIL mask_flag_check op %0d expected %0b actual %0b", $sampled(exp1_op),
               $sampled(exp1_is_mask), $sampled(out_is_mask));
    end

  mask_width_check: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_is_mask |-> out_data[`VCMP_DATA_WIDTH-1:`VCMP_BE_WIDTH] == '0)
    else begin
      errors++;
      $display("FAIL mask_width_check expected 0 actual %h",
               $sampled(out_data) >> `VCMP_BE_WIDTH);
    end

  initial begin
    vdata_t   a;
    vdata_t   b;
    vdata_t   most_neg;
    vdata_t   most_pos;
    vcmp_op_e o;
    vsew_t    s;
    int       wait_cycles;

    lfsr     = 32'ha5a58b4c;
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = VMINU;
    sew      = '0;
    vec0     = '0;
    vec1     = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // nothing sent yet, so out_valid has to stay low
    idle(5);

    // directed corners for every opcode at every element width
    for (int si = 0; si < 4; si++) begin
      s        = vsew_t'(si);
      most_neg = fill_elems(s, 8'h80, 8'h00);
      most_pos = fill_elems(s, 8'h7f, 8'hff);
      for (int oi = 0; oi < 10; oi++) begin
        o = vcmp_op_e'(4'(oi));
        a = rand_bits(64);
        send(o, s, a, a);
        send(o, s, most_neg, most_pos);
        send(o, s, most_pos, most_neg);
        send(o, s, '1, '0);
        send(o, s, '0, '1);
      end
    end
    idle(3);

    // random back-to-back traffic with the odd idle cycle
    for (int n = 0; n < 500; n++) begin
      o = vcmp_op_e'(4'(rand_bits(4) % 10));
      s = vsew_t'(rand_bits(2));
      a = rand_bits(64);
      b = rand_bits(64);
      // a single flipped bit leaves most elements equal
      if (rand_bits(2) == 0) begin
        b = a ^ (64'd1 << rand_bits(6));
      end
      send(o, s, a, b);
      if (rand_bits(3) == 0) begin
        idle(1);
      end
    end
    idle(1);

    wait_cycles = 0;
    while ((exp0_valid || exp1_valid || out_valid) && wait_cycles < 20) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    if (exp0_valid || exp1_valid || out_valid) begin
      timeouts++;
      $display("timeout while waiting for the pipeline to drain");
    end
    if (items_seen != items_sent) begin
      errors++;
      $display("%0d results came out for %0d inputs", items_seen, items_sent);
    end

    $display("summary: %0d sent, %0d checked, %0d errors, %0d timeouts",
             items_sent, items_seen, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
rtl/vcmp_types_pkg.sv
rtl/vcmp_op_pkg.sv
rtl/vsub_lanes.sv
rtl/vminmax_select.sv
rtl/vcmp_mask_gen.sv
rtl/vcmp_result_stage.sv
rtl/vcmp_unit.sv
dv/vcmp_unit_tb.sv

/* run.sh */
#!/bin/sh
# compiles the RTL and testbench with Verilator, runs the simulation and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module vcmp_unit_tb -f files.f --Mdir obj_dir \
  && ./obj_dir/Vvcmp_unit_tb > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
